//--- logic/mera_bus_pkg.sv
package mera_bus_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------

	// bus word, bit 0 is the MSB
	localparam int WORD_W = 16;
	// block (segment) number
	localparam int NB_W = 4;

	typedef logic [0:WORD_W-1] word_t;
	typedef logic [0:NB_W-1] nb_t;

	// --------------------------------------------------
	// memory geometry
	// --------------------------------------------------

	// frames present, blocks 0 and 1 only
	localparam int MEM_FRAMES = 2;
	// word select bits inside one frame
	localparam int FRAME_AW = 8;
	// frame select bits, taken from the low end of nb
	localparam int FRAME_BITS = $clog2(MEM_FRAMES);
	// full memory index width
	localparam int MEM_AW = FRAME_BITS + FRAME_AW;
	localparam int MEM_WORDS = MEM_FRAMES << FRAME_AW;

	// --------------------------------------------------
	// timing
	// --------------------------------------------------

	// cycles from req to ok inside the memory
	localparam int MEM_DLY = 2;
	// cycles from req to tmo when nothing answers
	localparam int ALARM_DLY_TICKS = 8;
	// timer counter width, holds ALARM_DLY_TICKS-1
	localparam int TMR_W = $clog2(ALARM_DLY_TICKS);

	// --------------------------------------------------
	// bus opcodes
	// --------------------------------------------------

	// kind of the open request
	typedef enum logic [1:0] {
		OP_NONE,
		OP_READ,
		OP_WRITE
	} bus_op_t;

endpackage

//--- logic/bus_if.sv
interface bus_if;

	// request side, driven by bus_io
	logic req;
	mera_bus_pkg::bus_op_t op;
	mera_bus_pkg::nb_t nb;
	mera_bus_pkg::word_t ad;
	mera_bus_pkg::word_t dt;

	// memory answer
	logic ok;
	mera_bus_pkg::word_t rd;

	// missing-memory timeout
	logic tmo;

	// bus_io: issues requests, collects outcomes
	modport io (
		output req, op, nb, ad, dt,
		input ok, rd, tmo
	);

	// memory block
	modport mem (
		input req, op, nb, ad, dt,
		output ok, rd
	);

	// watchdog only sees start and answer
	modport tmr (
		input req, ok,
		output tmo
	);

endinterface

//--- logic/bus_io.sv
module bus_io (
	input logic clk_sys,
	input logic reset,
	// master strobes
	input logic dw,
	input logic dr,
	input logic dmcl,
	input mera_bus_pkg::nb_t dnb,
	input mera_bus_pkg::word_t dad,
	input mera_bus_pkg::word_t ddt,
	// reply to master
	output logic rok,
	output logic ren,
	output logic busy,
	output logic awaria,
	output mera_bus_pkg::word_t rdt,
	// towards responders
	bus_if.io b
);

	mera_bus_pkg::bus_op_t op_dec;
	logic accept;

	// --------------------------------------------------
	// strobe decode
	// --------------------------------------------------

	// read wins when both strobes are up
	always_comb begin
		if (dr) begin
			op_dec = mera_bus_pkg::OP_READ;
		end else if (dw) begin
			op_dec = mera_bus_pkg::OP_WRITE;
		end else begin
			op_dec = mera_bus_pkg::OP_NONE;
		end
	end

	// strobes during busy are dropped
	assign accept = !busy && (op_dec != mera_bus_pkg::OP_NONE);

	// --------------------------------------------------
	// request register
	// --------------------------------------------------

	// one req pulse, op held for the whole transfer
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			b.req <= 1'b0;
			b.op <= mera_bus_pkg::OP_NONE;
		end else begin
			b.req <= accept;
			if (accept) begin
				b.op <= op_dec;
			end
		end
	end

	// payload fields, stable until the next accepted strobe
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			b.nb <= dnb;
			b.ad <= dad;
			b.dt <= ddt;
		end
	end

	// --------------------------------------------------
	// reply
	// --------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy <= 1'b0;
			rok <= 1'b0;
			ren <= 1'b0;
			awaria <= 1'b0;
			rdt <= '0;
		end else begin
			rok <= b.ok;
			ren <= b.tmo;
			// busy from accept to the first outcome
			if (accept) begin
				busy <= 1'b1;
			end else if (b.ok || b.tmo) begin
				busy <= 1'b0;
			end
			// read data only on a read answer
			if (b.ok && (b.op == mera_bus_pkg::OP_READ)) begin
				rdt <= b.rd;
			end
			// sticky alarm, a fresh timeout beats master clear
			if (b.tmo) begin
				awaria <= 1'b1;
			end else if (dmcl) begin
				awaria <= 1'b0;
			end
		end
	end

	// memory and watchdog never claim the same transfer
	a_ok_tmo_excl: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(b.ok && b.tmo)
	) else $error("ok and tmo high together");

	// master sees exactly one outcome per transfer
	a_rok_ren_excl: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(rok && ren)
	) else $error("rok and ren high together");

endmodule

//--- logic/mem_elwro.sv
module mem_elwro (
	input logic clk_sys,
	input logic reset,
	bus_if.mem b
);

	// word store
	mera_bus_pkg::word_t mem_q [mera_bus_pkg::MEM_WORDS];
	mera_bus_pkg::word_t rd_q;

	// delay line carries op and frame-present flag per stage
	mera_bus_pkg::bus_op_t dly_op [mera_bus_pkg::MEM_DLY];
	logic dly_hit [mera_bus_pkg::MEM_DLY];

	logic hit;
	logic in_flight;
	logic last_live;
	logic wr_fire;
	logic [mera_bus_pkg::MEM_AW-1:0] idx;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------

	// only the first MEM_FRAMES blocks exist
	assign hit = (b.nb < mera_bus_pkg::MEM_FRAMES);

	// frame from low nb bits and word from low ad bits (MSB-first numbering)
	assign idx = {
		b.nb[mera_bus_pkg::NB_W-mera_bus_pkg::FRAME_BITS +: mera_bus_pkg::FRAME_BITS],
		b.ad[mera_bus_pkg::WORD_W-mera_bus_pkg::FRAME_AW +: mera_bus_pkg::FRAME_AW]
	};

	// --------------------------------------------------
	// delay line
	// --------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < mera_bus_pkg::MEM_DLY; i++) begin
				dly_op[i] <= mera_bus_pkg::OP_NONE;
				dly_hit[i] <= 1'b0;
			end
		end else begin
			// stage 0 takes the new request
			dly_op[0] <= b.req ? b.op : mera_bus_pkg::OP_NONE;
			dly_hit[0] <= b.req && hit;
			for (int i = 1; i < mera_bus_pkg::MEM_DLY; i++) begin
				dly_op[i] <= dly_op[i-1];
				dly_hit[i] <= dly_hit[i-1];
			end
		end
	end

	// anything still travelling
	always_comb begin
		in_flight = 1'b0;
		for (int i = 0; i < mera_bus_pkg::MEM_DLY; i++) begin
			if (dly_op[i] != mera_bus_pkg::OP_NONE) begin
				in_flight = 1'b1;
			end
		end
	end

	// only present frames fire at the last stage
	assign last_live = dly_hit[mera_bus_pkg::MEM_DLY-1];
	assign wr_fire = last_live
		&& (dly_op[mera_bus_pkg::MEM_DLY-1] == mera_bus_pkg::OP_WRITE);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	// ad/dt are held by bus_io for the whole transfer
	always_ff @(posedge clk_sys) begin
		if (wr_fire) begin
			mem_q[idx] <= b.dt;
		end
		// registered read is valid once the line reaches its end
		rd_q <= mem_q[idx];
	end

	assign b.ok = last_live;
	assign b.rd = rd_q;

	// one open transfer at a time
	a_no_overlap: assert property (
		@(posedge clk_sys) disable iff (reset)
		b.req |-> !in_flight
	) else $error("new request while delay line busy");

endmodule

//--- logic/nomem_timer.sv
module nomem_timer (
	input logic clk_sys,
	input logic reset,
	bus_if.tmr b
);

	logic running;
	logic [mera_bus_pkg::TMR_W-1:0] cnt;

	// --------------------------------------------------
	// countdown
	// --------------------------------------------------

	// loaded on req and stopped by ok or by expiry
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			running <= 1'b0;
			cnt <= '0;
		end else if (b.req) begin
			running <= 1'b1;
			// last tick is the one where cnt reads zero
			cnt <= mera_bus_pkg::TMR_W'(mera_bus_pkg::ALARM_DLY_TICKS - 1);
		end else if (b.ok) begin
			running <= 1'b0;
			cnt <= '0;
		end else if (running) begin
			if (cnt == '0) begin
				running <= 1'b0;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// expiry pulse lasts one cycle since running drops next
	assign b.tmo = running && (cnt == '0);

	// timeout only a full count after a request, never from an idle counter
	a_tmo_after_req: assert property (
		@(posedge clk_sys) disable iff (reset)
		b.tmo |-> $past(b.req, mera_bus_pkg::ALARM_DLY_TICKS)
	) else $error("tmo while counter idle");

endmodule

//--- logic/mera_bus.sv
module mera_bus (
	input logic clk_sys,
	input logic reset,
	// master strobes and levels
	input logic dw,
	input logic dr,
	input logic dmcl,
	input mera_bus_pkg::nb_t dnb,
	input mera_bus_pkg::word_t dad,
	input mera_bus_pkg::word_t ddt,
	// reply
	output logic rok,
	output logic ren,
	output logic busy,
	output logic awaria,
	output mera_bus_pkg::word_t rdt
);

	// --------------------------------------------------
	// internal bus
	// --------------------------------------------------

	bus_if b_i ();

	// --------------------------------------------------
	// master side
	// --------------------------------------------------

	bus_io bio (
		.clk_sys(clk_sys),
		.reset(reset),
		.dw(dw),
		.dr(dr),
		.dmcl(dmcl),
		.dnb(dnb),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.ren(ren),
		.busy(busy),
		.awaria(awaria),
		.rdt(rdt),
		.b(b_i.io)
	);

	// --------------------------------------------------
	// responders, both see every request
	// --------------------------------------------------

	mem_elwro memory (
		.clk_sys(clk_sys),
		.reset(reset),
		.b(b_i.mem)
	);

	// no memory watchdog
	nomem_timer timer (
		.clk_sys(clk_sys),
		.reset(reset),
		.b(b_i.tmr)
	);

endmodule

//--- sim/tb_clock.sv
module tb_clock (
	output logic clk_sys,
	output logic reset
);

	// period 4
	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	// reset held over 4 rising edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

//--- sim/tb_mera_bus.sv
module tb_mera_bus;

	localparam int N_RAND = 300;
	localparam int N_DIRECTED = 14;
	localparam int N_XFERS = N_RAND + N_DIRECTED;
	// in clock periods
	localparam int RUN_LIMIT = N_XFERS * 16 + 100;
	localparam int WAIT_LIMIT = 20;
	localparam int ADDR_MASK = (1 << mera_bus_pkg::FRAME_AW) - 1;

	logic clk_sys;
	logic reset;
	logic dw;
	logic dr;
	logic dmcl;
	mera_bus_pkg::nb_t dnb;
	mera_bus_pkg::word_t dad;
	mera_bus_pkg::word_t ddt;
	logic rok;
	logic ren;
	logic busy;
	logic awaria;
	mera_bus_pkg::word_t rdt;

	// reference model, written words and alarm state
	mera_bus_pkg::word_t model_mem [int];
	int written_q [$];
	logic alarm_q;
	integer seed;

	tb_clock clk_gen (
		.clk_sys(clk_sys),
		.reset(reset)
	);

	mera_bus dut_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.dw(dw),
		.dr(dr),
		.dmcl(dmcl),
		.dnb(dnb),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.ren(ren),
		.busy(busy),
		.awaria(awaria),
		.rdt(rdt)
	);

	// --------------------------------------------------
	// failure and compare
	// --------------------------------------------------

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input mera_bus_pkg::word_t got, input mera_bus_pkg::word_t exp,
		input string what);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	// frame by block, word by the low address bits
	function automatic int mem_key(input mera_bus_pkg::nb_t nb, input mera_bus_pkg::word_t ad);
		return (int'(nb) << mera_bus_pkg::FRAME_AW) + (int'(ad) & ADDR_MASK);
	endfunction

	// --------------------------------------------------
	// bus actions
	// --------------------------------------------------

	// returns on a falling edge with busy low, no reply pulses meanwhile
	task automatic wait_idle();
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			check_flag(rok, 1'b0, "rok on idle bus");
			check_flag(ren, 1'b0, "ren on idle bus");
			check_flag(awaria, alarm_q, "awaria on idle bus");
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("busy stayed high while waiting for an idle bus");
			end
		end while (busy);
	endtask

	// one transfer, checked cycle by cycle from the strobe edge (cycle 0)
	task automatic run_xfer(input logic is_read, input mera_bus_pkg::nb_t nb,
		input mera_bus_pkg::word_t ad, input mera_bus_pkg::word_t dt,
		input logic both, input logic stray, input logic clr);
		int cyc;
		int done_cyc;
		int key;
		logic hit;
		mera_bus_pkg::word_t exp_rd;
		hit = (nb < mera_bus_pkg::MEM_FRAMES);
		// one cycle to req, responder delay, one cycle to the reply
		done_cyc = hit ? mera_bus_pkg::MEM_DLY + 2 : mera_bus_pkg::ALARM_DLY_TICKS + 2;
		key = mem_key(nb, ad);
		exp_rd = '0;
		if (is_read && hit) begin
			if (!model_mem.exists(key)) begin
				abort_run("stimulus reads an address that was never written");
			end
			exp_rd = model_mem[key];
		end
		wait_idle();
		dr = is_read;
		dw = !is_read || both;
		dnb = nb;
		dad = ad;
		ddt = dt;
		dmcl = 1'b0;
		cyc = 0;
		do begin
			@(negedge clk_sys);
			cyc++;
			// model state for this cycle
			if (cyc == 2 && clr) begin
				alarm_q = 1'b0;
			end
			if (cyc == done_cyc && !hit) begin
				alarm_q = 1'b1;
			end
			check_flag(rok, hit && cyc == done_cyc, "rok");
			check_flag(ren, !hit && cyc == done_cyc, "ren");
			check_flag(busy, cyc < done_cyc, "busy");
			check_flag(awaria, alarm_q, "awaria");
			if (cyc == done_cyc && hit) begin
				if (is_read) begin
					check_word(rdt, exp_rd, "rdt");
				end else begin
					if (!model_mem.exists(key)) begin
						written_q.push_back(key);
					end
					model_mem[key] = dt;
				end
			end
			// inputs for the next edge
			if (cyc == 1) begin
				dw = 1'b0;
				dr = 1'b0;
				// payload is latched, so junk here must not matter
				dnb = mera_bus_pkg::nb_t'($random(seed));
				dad = mera_bus_pkg::word_t'($random(seed));
				ddt = mera_bus_pkg::word_t'($random(seed));
				dmcl = clr;
			end else if (cyc == 2) begin
				dmcl = 1'b0;
				// strobe while busy, to be ignored
				if (stray) begin
					dw = 1'b1;
					dr = 1'($random(seed));
				end
			end else if (cyc == 3) begin
				dw = 1'b0;
				dr = 1'b0;
			end
			if (cyc >= WAIT_LIMIT && !(rok || ren)) begin
				abort_run("no reply from the bus within the expected time");
			end
		end while (!(rok || ren));
	endtask

	// master clear on an idle bus
	task automatic pulse_clear();
		wait_idle();
		dmcl = 1'b1;
		@(negedge clk_sys);
		dmcl = 1'b0;
		alarm_q = 1'b0;
		check_flag(awaria, 1'b0, "awaria after dmcl");
		check_flag(rok, 1'b0, "rok after dmcl");
		check_flag(ren, 1'b0, "ren after dmcl");
		check_flag(busy, 1'b0, "busy after dmcl");
	endtask

	// mixed traffic over blocks 0..3
	task automatic run_random();
		int key;
		int idx;
		logic is_read;
		logic both;
		logic stray;
		logic clr;
		mera_bus_pkg::nb_t nb;
		mera_bus_pkg::word_t ad;
		mera_bus_pkg::word_t dt;
		for (int i = 0; i < N_RAND; i++) begin
			is_read = 1'($random(seed));
			nb = mera_bus_pkg::nb_t'($random(seed) & 3);
			ad = mera_bus_pkg::word_t'($random(seed));
			dt = mera_bus_pkg::word_t'($random(seed));
			both = 1'($random(seed));
			stray = (($random(seed) & 3) == 0);
			clr = (($random(seed) & 7) == 0);
			// reads of present blocks only hit written words
			if (is_read && nb < mera_bus_pkg::MEM_FRAMES) begin
				if (written_q.size() == 0) begin
					is_read = 1'b0;
				end else begin
					idx = ($random(seed) & 32'h7fff_ffff) % written_q.size();
					key = written_q[idx];
					nb = mera_bus_pkg::nb_t'(key >> mera_bus_pkg::FRAME_AW);
					// upper address bits select nothing
					ad = mera_bus_pkg::word_t'((int'(ad) & ~ADDR_MASK) | (key & ADDR_MASK));
				end
			end
			run_xfer(is_read, nb, ad, dt, both, stray, clr);
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		seed = 97209;
		dw = 1'b0;
		dr = 1'b0;
		dmcl = 1'b0;
		dnb = '0;
		dad = '0;
		ddt = '0;
		alarm_q = 1'b0;

		// state right after reset
		@(negedge reset);
		@(negedge clk_sys);
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(rok, 1'b0, "rok after reset");
		check_flag(ren, 1'b0, "ren after reset");
		check_flag(awaria, 1'b0, "awaria after reset");
		check_word(rdt, '0, "rdt after reset");

		// writes and reads of present frames, same word in two blocks
		run_xfer(1'b0, 4'd0, 16'h1234, 16'hbeef, 1'b0, 1'b0, 1'b0);
		run_xfer(1'b0, 4'd1, 16'h0034, 16'h5a5a, 1'b0, 1'b0, 1'b0);
		run_xfer(1'b1, 4'd0, 16'hff34, 16'h0000, 1'b0, 1'b0, 1'b0);
		// both strobes, read wins
		run_xfer(1'b1, 4'd1, 16'h0034, 16'h0bad, 1'b1, 1'b0, 1'b0);

		// absent blocks time out, alarm stays up
		run_xfer(1'b1, 4'd2, 16'h0100, 16'h0000, 1'b0, 1'b0, 1'b0);
		run_xfer(1'b0, 4'd15, 16'h0200, 16'h7777, 1'b0, 1'b0, 1'b0);
		run_xfer(1'b0, 4'd0, 16'h0010, 16'h1111, 1'b0, 1'b0, 1'b0);

		// master clear drops the alarm
		pulse_clear();

		// strobes during busy
		run_xfer(1'b0, 4'd1, 16'h0010, 16'h2222, 1'b0, 1'b1, 1'b0);
		run_xfer(1'b1, 4'd1, 16'h0010, 16'h0000, 1'b0, 1'b1, 1'b0);
		run_xfer(1'b1, 4'd0, 16'h0034, 16'h0000, 1'b0, 1'b1, 1'b0);
		run_xfer(1'b1, 4'd3, 16'h0010, 16'h0000, 1'b0, 1'b1, 1'b0);

		// dmcl inside an open transfer
		run_xfer(1'b0, 4'd0, 16'h0020, 16'h3333, 1'b0, 1'b0, 1'b1);
		run_xfer(1'b1, 4'd0, 16'h0020, 16'h0000, 1'b0, 1'b0, 1'b1);

		run_random();

		$display("TEST PASSED");
		$finish;
	end

	// hang guard
	initial begin
		repeat (RUN_LIMIT) @(posedge clk_sys);
		abort_run("watchdog expired before all transfers finished");
	end

endmodule

//--- mera_bus.f
logic/mera_bus_pkg.sv
logic/bus_if.sv
logic/bus_io.sv
logic/mem_elwro.sv
logic/nomem_timer.sv
logic/mera_bus.sv
sim/tb_clock.sv
sim/tb_mera_bus.sv
